/* source/soc_pkg.sv */
// SoC memory and timer package
// Address map, packed address views, internal request/response and AXI4-Lite bundles
package soc_pkg;

  localparam int unsigned ADDR_W     = 16;
  localparam int unsigned DATA_W     = 64;
  localparam int unsigned STRB_W     = DATA_W / 8;
  localparam int unsigned NUM_BANKS  = 4;
  localparam int unsigned BANK_WORDS = 256;
  localparam int unsigned NUM_IRQ    = 4;

  localparam int unsigned BANK_IDX_W = $clog2(NUM_BANKS);
  localparam int unsigned WORD_IDX_W = $clog2(BANK_WORDS);
  localparam int unsigned CSR_IDX_W  = 3;

  // Timer CSR indices
  localparam logic [CSR_IDX_W-1:0] CSR_MTIME    = 3'd0;
  localparam logic [CSR_IDX_W-1:0] CSR_MTIMECMP = 3'd1;
  localparam logic [CSR_IDX_W-1:0] CSR_MINTEN   = 3'd2;
  localparam logic [CSR_IDX_W-1:0] CSR_SINTEN   = 3'd3;
  localparam logic [CSR_IDX_W-1:0] CSR_IRQ_PEND = 3'd4;
  localparam logic [CSR_IDX_W-1:0] NUM_CSR      = 3'd5;  // First unmapped index

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  // Region bit 15 is shared by both views, 0 = RAM, 1 = timer CSRs
  typedef struct packed {
    logic                  region;
    logic [1:0]            unused;
    logic [WORD_IDX_W-1:0] word;
    logic [BANK_IDX_W-1:0] bank;  // Word-interleaved banks
    logic [2:0]            offset;
  } ram_addr_t;

  typedef struct packed {
    logic                 region;
    logic [8:0]           unused;
    logic [CSR_IDX_W-1:0] reg_idx;
    logic [2:0]           offset;
  } csr_addr_t;

  typedef union packed {
    ram_addr_t ram;
    csr_addr_t csr;
  } soc_addr_u;

  typedef struct packed {
    logic              write;
    soc_addr_u         addr;
    logic [DATA_W-1:0] wdata;
    logic [STRB_W-1:0] strb;
  } mem_req_t;

  typedef struct packed {
    logic [DATA_W-1:0] rdata;
    logic              err;
  } mem_rsp_t;

  // Master-driven side
  typedef struct packed {
    logic              awvalid;
    logic [ADDR_W-1:0] awaddr;
    logic              wvalid;
    logic [DATA_W-1:0] wdata;
    logic [STRB_W-1:0] wstrb;
    logic              bready;
    logic              arvalid;
    logic [ADDR_W-1:0] araddr;
    logic              rready;
  } axil_req_t;

  // Slave-driven side
  typedef struct packed {
    logic              awready;
    logic              wready;
    logic              bvalid;
    logic [1:0]        bresp;
    logic              arready;
    logic              rvalid;
    logic [DATA_W-1:0] rdata;
    logic [1:0]        rresp;
  } axil_rsp_t;

  // Byte-lane merge used by every byte-writable register or word
  function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_word,
                                                    input logic [DATA_W-1:0] new_word,
                                                    input logic [STRB_W-1:0] strb);
    logic [DATA_W-1:0] res;
    res = old_word;
    for (int b = 0; b < STRB_W; b++) begin
      if (strb[b]) res[b*8 +: 8] = new_word[b*8 +: 8];
    end
    return res;
  endfunction

endpackage

/* source/axil_slave_port.sv */
// AXI4-Lite slave port
// Takes one read or write at a time, issues it inward as a single request pulse
// and holds the returned response on B or R until the master accepts it
`timescale 1ns/1ps

module axil_slave_port import soc_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  axil_req_t axil_req_i,
  output axil_rsp_t axil_rsp_o,
  output logic      req_valid_o,
  output mem_req_t  req_o,
  input  logic      rsp_valid_i,
  input  mem_rsp_t  rsp_i
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WAIT,
    ST_RESP
  } state_e;

  state_e            state_q;
  logic              aw_take;
  logic              ar_take;
  logic              is_read_q;
  logic              req_valid_q;
  mem_req_t          req_q;
  logic              bvalid_q;
  logic              rvalid_q;
  logic [DATA_W-1:0] rdata_q;
  logic [1:0]        resp_q;
  logic              rsp_done;

  // AW and W are taken together, a write wins over a read in the same cycle
  assign aw_take = (state_q == ST_IDLE) && axil_req_i.awvalid && axil_req_i.wvalid;
  assign ar_take = (state_q == ST_IDLE) && axil_req_i.arvalid && !aw_take;

  assign rsp_done = (bvalid_q && axil_req_i.bready) || (rvalid_q && axil_req_i.rready);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= ST_IDLE;
      is_read_q   <= 1'b0;
      req_valid_q <= 1'b0;
      bvalid_q    <= 1'b0;
      rvalid_q    <= 1'b0;
    end else begin
      req_valid_q <= aw_take || ar_take;  // One-cycle pulse
      case (state_q)
        ST_IDLE: begin
          if (aw_take || ar_take) begin
            state_q   <= ST_WAIT;
            is_read_q <= ar_take;
          end
        end
        ST_WAIT: begin
          if (rsp_valid_i) begin
            state_q  <= ST_RESP;
            bvalid_q <= !is_read_q;
            rvalid_q <= is_read_q;
          end
        end
        ST_RESP: begin
          if (rsp_done) begin
            state_q  <= ST_IDLE;
            bvalid_q <= 1'b0;
            rvalid_q <= 1'b0;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Request and response payload
  always_ff @(posedge clk_i) begin
    if (aw_take) begin
      req_q.write <= 1'b1;
      req_q.addr  <= soc_addr_u'(axil_req_i.awaddr);
      req_q.wdata <= axil_req_i.wdata;
      req_q.strb  <= axil_req_i.wstrb;
    end else if (ar_take) begin
      req_q.write <= 1'b0;
      req_q.addr  <= soc_addr_u'(axil_req_i.araddr);
      req_q.wdata <= '0;
      req_q.strb  <= '0;
    end
    if (state_q == ST_WAIT && rsp_valid_i) begin
      rdata_q <= rsp_i.rdata;
      resp_q  <= rsp_i.err ? RESP_SLVERR : RESP_OKAY;
    end
  end

  assign req_valid_o = req_valid_q;
  assign req_o       = req_q;

  always_comb begin
    axil_rsp_o         = '0;
    axil_rsp_o.awready = aw_take;
    axil_rsp_o.wready  = aw_take;
    axil_rsp_o.arready = ar_take;
    axil_rsp_o.bvalid  = bvalid_q;
    axil_rsp_o.bresp   = resp_q;
    axil_rsp_o.rvalid  = rvalid_q;
    axil_rsp_o.rdata   = rdata_q;
    axil_rsp_o.rresp   = resp_q;
  end

endmodule

/* source/req_stage.sv */
// Request pipeline stage
// Registers the issued request and decodes its target into one-hot valids
`timescale 1ns/1ps

module req_stage import soc_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 req_valid_i,
  input  mem_req_t             req_i,
  output mem_req_t             req_o,
  output logic [NUM_BANKS-1:0] bank_valid_o,
  output logic                 csr_valid_o
);

  mem_req_t             req_q;
  logic [NUM_BANKS-1:0] bank_valid_d;
  logic [NUM_BANKS-1:0] bank_valid_q;
  logic                 csr_valid_q;
  logic                 is_csr;

  assign is_csr = req_i.addr.ram.region;  // Same bit in either view

  always_comb begin
    bank_valid_d = '0;
    if (req_valid_i && !is_csr) begin
      bank_valid_d[req_i.addr.ram.bank] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bank_valid_q <= '0;
      csr_valid_q  <= 1'b0;
    end else begin
      bank_valid_q <= bank_valid_d;
      csr_valid_q  <= req_valid_i && is_csr;
    end
  end

  // Shared by all targets, only the selected one acts on it
  always_ff @(posedge clk_i) begin
    if (req_valid_i) begin
      req_q <= req_i;
    end
  end

  assign req_o        = req_q;
  assign bank_valid_o = bank_valid_q;
  assign csr_valid_o  = csr_valid_q;

endmodule

/* source/ram_bank.sv */
// RAM bank
// Byte-writable 64-bit words with a registered read response
`timescale 1ns/1ps

module ram_bank import soc_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     req_valid_i,
  input  mem_req_t req_i,
  output logic     rsp_valid_o,
  output mem_rsp_t rsp_o
);

  logic [DATA_W-1:0]     mem_q [BANK_WORDS];
  logic [DATA_W-1:0]     rdata_q;
  logic                  rsp_valid_q;
  logic [WORD_IDX_W-1:0] word_idx;

  assign word_idx = req_i.addr.ram.word;

  always_ff @(posedge clk_i) begin
    if (req_valid_i) begin
      if (req_i.write) begin
        mem_q[word_idx] <= merge_bytes(mem_q[word_idx], req_i.wdata, req_i.strb);
      end
      rdata_q <= mem_q[word_idx];  // Old word on a write
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) rsp_valid_q <= 1'b0;
    else         rsp_valid_q <= req_valid_i;
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_o.rdata = rdata_q;
  assign rsp_o.err   = 1'b0;

endmodule

/* source/rsp_stage.sv */
// Response pipeline stage
// Merges the one-hot target responses into one registered response
`timescale 1ns/1ps

module rsp_stage import soc_pkg::*; (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic     [NUM_BANKS-1:0]       bank_valid_i,
  input  mem_rsp_t [NUM_BANKS-1:0]       bank_rsp_i,
  input  logic                           csr_valid_i,
  input  mem_rsp_t                       csr_rsp_i,
  output logic                           rsp_valid_o,
  output mem_rsp_t                       rsp_o
);

  mem_rsp_t rsp_d;
  mem_rsp_t rsp_q;
  logic     rsp_valid_q;

  // At most one valid is high, so an AND-OR merge is enough
  always_comb begin
    rsp_d = csr_valid_i ? csr_rsp_i : '0;
    for (int b = 0; b < NUM_BANKS; b++) begin
      if (bank_valid_i[b]) rsp_d = rsp_d | bank_rsp_i[b];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) rsp_valid_q <= 1'b0;
    else         rsp_valid_q <= csr_valid_i || (|bank_valid_i);
  end

  always_ff @(posedge clk_i) begin
    rsp_q <= rsp_d;
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_o       = rsp_q;

endmodule

/* source/timer_irq.sv */
// Timer and interrupt block
// Free-running mtime, mtimecmp compare and machine/supervisor interrupt masks,
// all reachable as CSRs, with registered interrupt outputs
`timescale 1ns/1ps

module timer_irq import soc_pkg::*; (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               req_valid_i,
  input  mem_req_t           req_i,
  output logic               rsp_valid_o,
  output mem_rsp_t           rsp_o,
  input  logic [NUM_IRQ-1:0] irq_src_i,
  output logic               mtip_o,
  output logic               meip_o,
  output logic               seip_o
);

  logic [DATA_W-1:0]    mtime_q;
  logic [DATA_W-1:0]    mtimecmp_q;
  logic [DATA_W-1:0]    minten_q;
  logic [DATA_W-1:0]    sinten_q;
  logic [CSR_IDX_W-1:0] csr_idx;
  logic                 wr_en;
  logic                 csr_err;
  logic [DATA_W-1:0]    rd_data;
  logic                 rsp_valid_q;
  mem_rsp_t             rsp_q;
  logic                 mtip_q;
  logic                 meip_q;
  logic                 seip_q;

  assign csr_idx = req_i.addr.csr.reg_idx;
  assign wr_en   = req_valid_i && req_i.write;
  assign csr_err = csr_idx >= NUM_CSR;

  always_comb begin
    case (csr_idx)
      CSR_MTIME:    rd_data = mtime_q;
      CSR_MTIMECMP: rd_data = mtimecmp_q;
      CSR_MINTEN:   rd_data = minten_q;
      CSR_SINTEN:   rd_data = sinten_q;
      CSR_IRQ_PEND: rd_data = {{(DATA_W-NUM_IRQ){1'b0}}, irq_src_i};  // Raw sources
      default:      rd_data = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mtime_q     <= '0;
      mtimecmp_q  <= '1;  // No timer interrupt out of reset
      minten_q    <= '0;
      sinten_q    <= '0;
      rsp_valid_q <= 1'b0;
      mtip_q      <= 1'b0;
      meip_q      <= 1'b0;
      seip_q      <= 1'b0;
    end else begin
      mtime_q <= mtime_q + 1'b1;
      if (wr_en && csr_idx == CSR_MTIME) begin
        mtime_q <= merge_bytes(mtime_q, req_i.wdata, req_i.strb);
      end
      if (wr_en && csr_idx == CSR_MTIMECMP) begin
        mtimecmp_q <= merge_bytes(mtimecmp_q, req_i.wdata, req_i.strb);
      end
      if (wr_en && csr_idx == CSR_MINTEN) begin
        minten_q <= merge_bytes(minten_q, req_i.wdata, req_i.strb);
      end
      if (wr_en && csr_idx == CSR_SINTEN) begin
        sinten_q <= merge_bytes(sinten_q, req_i.wdata, req_i.strb);
      end
      rsp_valid_q <= req_valid_i;
      // Level interrupts, one cycle behind the state
      mtip_q <= mtime_q >= mtimecmp_q;
      meip_q <= |(irq_src_i & minten_q[NUM_IRQ-1:0]);
      seip_q <= |(irq_src_i & sinten_q[NUM_IRQ-1:0]);
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_valid_i) begin
      rsp_q.rdata <= rd_data;  // Zero for unmapped indices
      rsp_q.err   <= csr_err;
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_o       = rsp_q;
  assign mtip_o      = mtip_q;
  assign meip_o      = meip_q;
  assign seip_o      = seip_q;

endmodule

/* source/soc_mem_top.sv */
// SoC memory and interrupt top level
// AXI4-Lite port feeding four interleaved RAM banks and the timer/interrupt block
`timescale 1ns/1ps

module soc_mem_top import soc_pkg::*; (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  axil_req_t          axil_req_i,
  output axil_rsp_t          axil_rsp_o,
  input  logic [NUM_IRQ-1:0] irq_src_i,
  output logic               mtip_o,
  output logic               meip_o,
  output logic               seip_o
);

  logic                           port_req_valid;
  mem_req_t                       port_req;
  mem_req_t                       stage_req;
  logic     [NUM_BANKS-1:0]       bank_req_valid;
  logic                           csr_req_valid;
  logic     [NUM_BANKS-1:0]       bank_rsp_valid;
  mem_rsp_t [NUM_BANKS-1:0]       bank_rsp;
  logic                           csr_rsp_valid;
  mem_rsp_t                       csr_rsp;
  logic                           rsp_valid;
  mem_rsp_t                       rsp;

  axil_slave_port u_port (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .axil_req_i  (axil_req_i),
    .axil_rsp_o  (axil_rsp_o),
    .req_valid_o (port_req_valid),
    .req_o       (port_req),
    .rsp_valid_i (rsp_valid),
    .rsp_i       (rsp)
  );

  req_stage u_req_stage (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_valid_i  (port_req_valid),
    .req_i        (port_req),
    .req_o        (stage_req),
    .bank_valid_o (bank_req_valid),
    .csr_valid_o  (csr_req_valid)
  );

  for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
    ram_bank u_bank (
      .clk_i       (clk_i),
      .rst_ni      (rst_ni),
      .req_valid_i (bank_req_valid[b]),
      .req_i       (stage_req),
      .rsp_valid_o (bank_rsp_valid[b]),
      .rsp_o       (bank_rsp[b])
    );
  end

  timer_irq u_timer (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_valid_i (csr_req_valid),
    .req_i       (stage_req),
    .rsp_valid_o (csr_rsp_valid),
    .rsp_o       (csr_rsp),
    .irq_src_i   (irq_src_i),
    .mtip_o      (mtip_o),
    .meip_o      (meip_o),
    .seip_o      (seip_o)
  );

  rsp_stage u_rsp_stage (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .bank_valid_i (bank_rsp_valid),
    .bank_rsp_i   (bank_rsp),
    .csr_valid_i  (csr_rsp_valid),
    .csr_rsp_i    (csr_rsp),
    .rsp_valid_o  (rsp_valid),
    .rsp_o        (rsp)
  );

endmodule

/* tb/soc_mem_properties.sv */
// AXI4-Lite and interrupt properties for the SoC memory top level
// Bound into soc_mem_top, checks response holding, single outstanding
// transaction and quiet interrupt outputs around reset
`timescale 1ns/1ps

module soc_mem_properties import soc_pkg::*; (
  input logic      clk_i,
  input logic      rst_ni,
  input axil_req_t axil_req_i,
  input axil_rsp_t axil_rsp_i,
  input logic      mtip_i,
  input logic      meip_i,
  input logic      seip_i
);

  int unsigned fail_cnt = 0;  // Failed assertion count
  logic        busy_q;
  logic        req_hs;
  logic        rsp_hs;
  logic        any_ready;

  assign req_hs = (axil_req_i.awvalid && axil_rsp_i.awready) ||
                  (axil_req_i.arvalid && axil_rsp_i.arready);
  assign rsp_hs = (axil_rsp_i.bvalid && axil_req_i.bready) ||
                  (axil_rsp_i.rvalid && axil_req_i.rready);
  assign any_ready = axil_rsp_i.awready || axil_rsp_i.wready || axil_rsp_i.arready;

  // Set from the address handshake until the response handshake
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
    end else if (req_hs) begin
      busy_q <= 1'b1;
    end else if (rsp_hs) begin
      busy_q <= 1'b0;
    end
  end

  a_b_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    axil_rsp_i.bvalid && !axil_req_i.bready |=> axil_rsp_i.bvalid && $stable(axil_rsp_i.bresp))
  else begin
    $error("B response dropped or changed before bready");
    fail_cnt++;
  end

  a_r_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    axil_rsp_i.rvalid && !axil_req_i.rready |=> axil_rsp_i.rvalid &&
      $stable(axil_rsp_i.rdata) && $stable(axil_rsp_i.rresp))
  else begin
    $error("R response dropped or changed before rready");
    fail_cnt++;
  end

  a_no_ready_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
    busy_q |-> !any_ready)
  else begin
    $error("Ready raised while a transaction is outstanding");
    fail_cnt++;
  end

  // No disable here, reset itself is the condition
  a_irq_reset: assert property (@(posedge clk_i)
    (!rst_ni || $rose(rst_ni)) |-> !(mtip_i || meip_i || seip_i))
  else begin
    $error("Interrupt output high around reset");
    fail_cnt++;
  end

endmodule

bind soc_mem_top soc_mem_properties u_props (
  .clk_i      (clk_i),
  .rst_ni     (rst_ni),
  .axil_req_i (axil_req_i),
  .axil_rsp_i (axil_rsp_o),
  .mtip_i     (mtip_o),
  .meip_i     (meip_o),
  .seip_i     (seip_o)
);

/* tb/soc_mem_tb.sv */
// Testbench for the SoC memory and interrupt top level
// LFSR-driven AXI4-Lite traffic checked against a shadow RAM and the timer rules
`timescale 1ns/1ps

module soc_mem_tb import soc_pkg::*; ();

  localparam int NUM_RAM_WR = 32;
  localparam int NUM_STRB   = 16;
  localparam int NUM_IRQ_RUNS = 8;
  // RAM writes and reads, strobe pairs, timer, masks, unmapped CSRs
  localparam int NUM_TXN = 2*NUM_RAM_WR + 2*NUM_STRB + 5 + 3*NUM_IRQ_RUNS + 5;
  localparam int WATCHDOG_CYCLES = NUM_TXN*40 + 1000;  // Margin covers the mtip wait

  logic               clk;
  logic               rst_n;
  axil_req_t          axil_req;
  axil_rsp_t          axil_rsp;
  logic [NUM_IRQ-1:0] irq_src;
  logic               mtip;
  logic               meip;
  logic               seip;
  logic [31:0]        lfsr_q = 32'h7e68;
  logic [DATA_W-1:0]  shadow [NUM_BANKS*BANK_WORDS];  // Indexed by {word, bank}
  int unsigned        err_cnt = 0;

  soc_mem_top u_dut (
    .clk_i      (clk),
    .rst_ni     (rst_n),
    .axil_req_i (axil_req),
    .axil_rsp_o (axil_rsp),
    .irq_src_i  (irq_src),
    .mtip_o     (mtip),
    .meip_o     (meip),
    .seip_o     (seip)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Simulation timed out after %0d cycles", WATCHDOG_CYCLES);
    $display("SOME TESTS FAILED");
    $finish;
  end

  // Fibonacci LFSR, x^32 + x^22 + x^2 + x + 1, one step per bit
  function automatic logic [DATA_W-1:0] rand_bits(input int n);
    logic [DATA_W-1:0] val;
    logic              fb;
    val = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      val    = {val[DATA_W-2:0], fb};
    end
    return val;
  endfunction

  function automatic logic [ADDR_W-1:0] ram_addr(input logic [9:0] slot);
    return {1'b0, 2'b00, slot, 3'b000};
  endfunction

  function automatic logic [ADDR_W-1:0] csr_addr(input logic [2:0] idx);
    return {1'b1, 9'd0, idx, 3'b000};
  endfunction

  // Byte mask model of a strobed write
  function automatic logic [DATA_W-1:0] apply_strobes(input logic [DATA_W-1:0] old_word,
                                                      input logic [DATA_W-1:0] new_word,
                                                      input logic [STRB_W-1:0] strb);
    logic [DATA_W-1:0] mask;
    for (int i = 0; i < STRB_W; i++) mask[8*i +: 8] = {8{strb[i]}};
    return (old_word & ~mask) | (new_word & mask);
  endfunction

  task automatic expect_eq(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
                           input string what);
    assert (got === exp) else begin
      $display("ERROR %0t: %s got %h expected %h", $time, what, got, exp);
      err_cnt++;
    end
  endtask

  // One AXI4-Lite transaction with 0 to 7 cycles of response back-pressure
  task automatic axi_access(input logic is_write, input logic [ADDR_W-1:0] addr,
                            input logic [DATA_W-1:0] data, input logic [STRB_W-1:0] strb,
                            output logic [DATA_W-1:0] rdata, output logic [1:0] resp);
    logic [DATA_W-1:0] rnd;
    int                hold;
    int                lat;
    rnd   = rand_bits(3);
    hold  = int'(rnd[2:0]);
    rdata = '0;
    resp  = RESP_SLVERR;
    if (is_write) begin
      axil_req.awvalid = 1'b1;
      axil_req.awaddr  = addr;
      axil_req.wvalid  = 1'b1;
      axil_req.wdata   = data;
      axil_req.wstrb   = strb;
    end else begin
      axil_req.arvalid = 1'b1;
      axil_req.araddr  = addr;
    end
    @(negedge clk);  // Ready is combinational, look mid-cycle
    while (!(is_write ? axil_rsp.awready : axil_rsp.arready)) @(negedge clk);
    if (is_write) begin
      expect_eq(64'(axil_rsp.wready), 64'd1, "wready with awready");
    end
    @(posedge clk);
    #1;
    axil_req.awvalid = 1'b0;
    axil_req.wvalid  = 1'b0;
    axil_req.arvalid = 1'b0;
    lat = 0;
    while (!(is_write ? axil_rsp.bvalid : axil_rsp.rvalid) && lat < 20) begin
      @(posedge clk);
      #1;
      lat++;
    end
    if (!(is_write ? axil_rsp.bvalid : axil_rsp.rvalid)) begin
      $display("No response within 20 cycles of the handshake at %0t", $time);
      err_cnt++;
      return;
    end
    expect_eq(64'(lat), 64'd4, "response latency");
    rdata = axil_rsp.rdata;
    resp  = is_write ? axil_rsp.bresp : axil_rsp.rresp;
    repeat (hold) begin
      @(posedge clk);
      #1;
    end
    axil_req.bready = is_write;
    axil_req.rready = !is_write;
    @(posedge clk);
    #1;
    axil_req.bready = 1'b0;
    axil_req.rready = 1'b0;
  endtask

  initial begin : main
    logic [DATA_W-1:0]  rnd;
    logic [DATA_W-1:0]  data;
    logic [DATA_W-1:0]  rd;
    logic [DATA_W-1:0]  base;
    logic [1:0]         resp;
    logic [9:0]         slots [NUM_RAM_WR];
    logic [STRB_W-1:0]  strb;
    logic [NUM_IRQ-1:0] src;
    logic [NUM_IRQ-1:0] men;
    logic [NUM_IRQ-1:0] sen;
    int                 wait_cnt;
    int unsigned        prop_errs;

    rst_n    = 1'b0;
    axil_req = '0;
    irq_src  = '0;
    repeat (4) @(posedge clk);
    #1 rst_n = 1'b1;
    repeat (2) @(posedge clk);
    #1;

    // RAM round trip, bank index follows the loop count
    for (int i = 0; i < NUM_RAM_WR; i++) begin
      rnd      = rand_bits(WORD_IDX_W);
      slots[i] = {rnd[WORD_IDX_W-1:0], 2'(i)};
      data     = rand_bits(DATA_W);
      axi_access(1'b1, ram_addr(slots[i]), data, '1, rd, resp);
      expect_eq(64'(resp), 64'(RESP_OKAY), "RAM write response");
      shadow[slots[i]] = data;
    end
    for (int i = 0; i < NUM_RAM_WR; i++) begin
      axi_access(1'b0, ram_addr(slots[i]), '0, '0, rd, resp);
      expect_eq(64'(resp), 64'(RESP_OKAY), "RAM read response");
      expect_eq(rd, shadow[slots[i]], "RAM read data");
    end

    // Partial strobes over words already written
    for (int i = 0; i < NUM_STRB; i++) begin
      rnd  = rand_bits(STRB_W);
      strb = rnd[STRB_W-1:0];
      data = rand_bits(DATA_W);
      axi_access(1'b1, ram_addr(slots[i]), data, strb, rd, resp);
      expect_eq(64'(resp), 64'(RESP_OKAY), "strobed write response");
      shadow[slots[i]] = apply_strobes(shadow[slots[i]], data, strb);
      axi_access(1'b0, ram_addr(slots[i]), '0, '0, rd, resp);
      expect_eq(rd, shadow[slots[i]], "strobed read data");
    end

    // Timer compare
    axi_access(1'b1, csr_addr(CSR_MTIMECMP), '1, '1, rd, resp);
    rnd  = rand_bits(32);
    base = {32'd0, rnd[31:0]};
    axi_access(1'b1, csr_addr(CSR_MTIME), base, '1, rd, resp);
    axi_access(1'b0, csr_addr(CSR_MTIME), '0, '0, rd, resp);
    assert (rd >= base && rd <= base + 64'd40) else begin
      $display("ERROR %0t: mtime read %0d outside %0d to %0d", $time, rd, base, base + 64'd40);
      err_cnt++;
    end
    axi_access(1'b1, csr_addr(CSR_MTIMECMP), base + 64'd200, '1, rd, resp);
    expect_eq(64'(mtip), 64'd0, "mtip_o before compare");
    wait_cnt = 0;
    while (!mtip && wait_cnt < 300) begin
      @(posedge clk);
      #1;
      wait_cnt++;
    end
    assert (mtip) else begin
      $display("ERROR %0t: mtip_o still low after 300 cycles", $time);
      err_cnt++;
    end
    axi_access(1'b1, csr_addr(CSR_MTIMECMP), '1, '1, rd, resp);
    repeat (2) begin
      @(posedge clk);
      #1;
    end
    expect_eq(64'(mtip), 64'd0, "mtip_o after compare reset");

    // Interrupt masks
    for (int i = 0; i < NUM_IRQ_RUNS; i++) begin
      rnd = rand_bits(3*NUM_IRQ);
      src = rnd[NUM_IRQ-1:0];
      men = rnd[2*NUM_IRQ-1:NUM_IRQ];
      sen = rnd[3*NUM_IRQ-1:2*NUM_IRQ];
      axi_access(1'b1, csr_addr(CSR_MINTEN), 64'(men), '1, rd, resp);
      axi_access(1'b1, csr_addr(CSR_SINTEN), 64'(sen), '1, rd, resp);
      irq_src = src;
      repeat (2) begin
        @(posedge clk);
        #1;
      end
      expect_eq(64'(meip), 64'(|(src & men)), "meip_o");
      expect_eq(64'(seip), 64'(|(src & sen)), "seip_o");
      axi_access(1'b0, csr_addr(CSR_IRQ_PEND), '0, '0, rd, resp);
      expect_eq(rd, 64'(src), "IRQ_PEND read");
    end

    // Unmapped CSR indices
    for (int idx = 5; idx < 8; idx++) begin
      axi_access(1'b0, csr_addr(3'(idx)), '0, '0, rd, resp);
      expect_eq(64'(resp), 64'(RESP_SLVERR), "unmapped read response");
      expect_eq(rd, 64'd0, "unmapped read data");
    end
    data = rand_bits(DATA_W);
    axi_access(1'b1, csr_addr(3'd6), data, '1, rd, resp);  // Same low bits as minten
    expect_eq(64'(resp), 64'(RESP_SLVERR), "unmapped write response");
    axi_access(1'b0, csr_addr(CSR_MINTEN), '0, '0, rd, resp);
    expect_eq(rd, 64'(men), "minten after unmapped write");

    repeat (4) @(posedge clk);
    prop_errs = u_dut.u_props.fail_cnt;
    $display("Check errors: %0d, property errors: %0d", err_cnt, prop_errs);
    if (err_cnt == 0 && prop_errs == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

/* soc_mem_top.f */
source/soc_pkg.sv
source/axil_slave_port.sv
source/req_stage.sv
source/ram_bank.sv
source/rsp_stage.sv
source/timer_irq.sv
source/soc_mem_top.sv
tb/soc_mem_properties.sv
tb/soc_mem_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the SoC memory testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=soc_mem_sim
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f soc_mem_top.f --top-module soc_mem_tb \
  -Mdir "$BUILD_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/$SIM_BIN" +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^ALL TESTS PASSED$" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1
